// ==== Makefile ====
# Verilator build and run for the conv_freq testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

FAIL_MSG = Simulation finished: FAIL
PASS_MSG = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/complex_mac_lane.sv ====
// complex MAC lane
// registered full-precision product, then accumulate over one kernel's D1 pairs
`timescale 1ns/1ps
`default_nettype none

module complex_mac_lane import conv_freq_pkg::*; #(
  parameter int LANE_INDEX = 0
) (
  input  wire logic clk,
  input  wire logic reset,
  lane_if.sink      ops,
  output logic      acc_valid,
  output acc_complex_t acc_out
);

  complex_t a;
  complex_t b;
  logic signed [2*DATA_W-1:0] rr, ii, ri, ir;
  acc_complex_t prod;
  logic prod_valid;
  logic prod_first;
  logic prod_last;
  acc_complex_t acc;
  acc_complex_t sum;

  assign a = ops.image_op[LANE_INDEX];
  assign b = ops.kernel_op[LANE_INDEX];

  assign rr = a.re * b.re;
  assign ii = a.im * b.im;
  assign ri = a.re * b.im;
  assign ir = a.im * b.re;

  // stage 1: product, no rounding
  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= ops.op_valid;
    end
    prod_first <= ops.op_first;
    prod_last <= ops.op_last;
    prod.re <= ACC_W'(rr) - ACC_W'(ii);
    prod.im <= ACC_W'(ri) + ACC_W'(ir);
  end

  // first pair restarts the sum instead of adding to the old one
  assign sum.re = prod_first ? prod.re : acc.re + prod.re;
  assign sum.im = prod_first ? prod.im : acc.im + prod.im;

  // stage 2: accumulate, hand off the finished sum on last
  always_ff @(posedge clk) begin
    if (reset) begin
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= prod_valid && prod_last;
    end
    if (prod_valid) begin
      acc <= sum;
      if (prod_last) begin
        acc_out <= sum;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/conv_freq_pkg.sv ====
// conv_freq shared definitions
// line widths, complex sample types and the sequencer state encoding
`default_nettype none

package conv_freq_pkg;

  // complex points per line, one MAC lane per point
  localparam int LANES = 4;
  localparam int DATA_W = 16;
  // accumulator headroom for up to 2^IMG_DEPTH_BITS full-scale products
  localparam int ACC_W = 40;

  typedef struct packed {
    logic signed [DATA_W-1:0] re;
    logic signed [DATA_W-1:0] im;
  } complex_t;

  typedef struct packed {
    logic signed [ACC_W-1:0] re;
    logic signed [ACC_W-1:0] im;
  } acc_complex_t;

  typedef complex_t [LANES-1:0] tile_t;
  typedef acc_complex_t [LANES-1:0] result_t;

  typedef enum logic [1:0] {
    EXEC_IDLE,
    EXEC_RUN,
    EXEC_FLUSH
  } exec_state_t;

endpackage

`default_nettype wire

// ==== design/conv_freq_top.sv ====
// frequency-domain convolution core
// image and kernel buffers, MAC sequencer, LANES complex MAC lanes and collector
`timescale 1ns/1ps
`default_nettype none

module conv_freq_top import conv_freq_pkg::*; #(
  parameter int IMG_DEPTH_BITS = 4,
  parameter int KER_DEPTH_BITS = 6
) (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire logic                    image_we,
  input  wire tile_t                   image_line,
  input  wire logic                    kernel_we,
  input  wire tile_t                   kernel_line,
  input  wire logic                    start,
  input  wire logic [IMG_DEPTH_BITS:0] num_in_maps,
  input  wire logic [KER_DEPTH_BITS:0] num_out_maps,
  output logic                         result_valid,
  output result_t                      result_line,
  output logic                         done
);

  logic [IMG_DEPTH_BITS-1:0] image_addr;
  logic [KER_DEPTH_BITS-1:0] kernel_addr;
  tile_t image_rd_line;
  tile_t kernel_rd_line;
  logic job_clear;
  logic [LANES-1:0] lane_valid;
  result_t lane_acc;

  lane_if ops ();

  tile_buffer #(.DEPTH_BITS(IMG_DEPTH_BITS)) image_buffer (
    .clk     (clk),
    .reset   (reset),
    .clear   (job_clear),
    .we      (image_we),
    .wr_line (image_line),
    .rd_addr (image_addr),
    .rd_line (image_rd_line)
  );

  tile_buffer #(.DEPTH_BITS(KER_DEPTH_BITS)) kernel_buffer (
    .clk     (clk),
    .reset   (reset),
    .clear   (job_clear),
    .we      (kernel_we),
    .wr_line (kernel_line),
    .rd_addr (kernel_addr),
    .rd_line (kernel_rd_line)
  );

  mac_sequencer #(
    .IMG_DEPTH_BITS (IMG_DEPTH_BITS),
    .KER_DEPTH_BITS (KER_DEPTH_BITS)
  ) i_mac_sequencer (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .num_in_maps  (num_in_maps),
    .num_out_maps (num_out_maps),
    .image_addr   (image_addr),
    .kernel_addr  (kernel_addr),
    .image_line   (image_rd_line),
    .kernel_line  (kernel_rd_line),
    .ops          (ops.source),
    .job_clear    (job_clear)
  );

  // one lane per complex point of a line
  for (genvar g = 0; g < LANES; g++) begin : gen_lane
    complex_mac_lane #(.LANE_INDEX(g)) i_lane (
      .clk       (clk),
      .reset     (reset),
      .ops       (ops.sink),
      .acc_valid (lane_valid[g]),
      .acc_out   (lane_acc[g])
    );
  end

  result_collector #(.KER_DEPTH_BITS(KER_DEPTH_BITS)) i_result_collector (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .num_out_maps (num_out_maps),
    .lane_valid   (lane_valid),
    .lane_acc     (lane_acc),
    .result_valid (result_valid),
    .result_line  (result_line),
    .done         (done)
  );

endmodule

`default_nettype wire

// ==== design/lane_if.sv ====
// operand stream from the sequencer to the MAC lanes
// one image/kernel line pair per cycle, no handshake
`timescale 1ns/1ps
`default_nettype none

interface lane_if import conv_freq_pkg::*; ();

  logic  op_valid;
  logic  op_first;
  logic  op_last;
  tile_t image_op;
  tile_t kernel_op;

  modport source (
    output op_valid, op_first, op_last, image_op, kernel_op
  );

  modport sink (
    input op_valid, op_first, op_last, image_op, kernel_op
  );

endinterface

`default_nettype wire

// ==== design/mac_sequencer.sv ====
// MAC sequencer
// walks image lines 0..D1-1 against each kernel window and flags sum boundaries
`timescale 1ns/1ps
`default_nettype none

module mac_sequencer import conv_freq_pkg::*; #(
  parameter int IMG_DEPTH_BITS = 4,
  parameter int KER_DEPTH_BITS = 6
) (
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire logic                      start,
  input  wire logic [IMG_DEPTH_BITS:0]   num_in_maps,
  input  wire logic [KER_DEPTH_BITS:0]   num_out_maps,
  output logic [IMG_DEPTH_BITS-1:0]      image_addr,
  output logic [KER_DEPTH_BITS-1:0]      kernel_addr,
  input  wire tile_t                     image_line,
  input  wire tile_t                     kernel_line,
  lane_if.source                         ops,
  output logic                           job_clear
);

  // one extra bit so a full kernel buffer can be counted
  typedef logic [KER_DEPTH_BITS:0] kcount_t;

  exec_state_t state;
  kcount_t d1;
  kcount_t d2;
  logic [IMG_DEPTH_BITS-1:0] img_pos;
  kcount_t ker_pos;
  kcount_t ker_end;
  kcount_t kernel_cnt;
  logic first_now;
  logic last_now;

  // window boundaries for the pair addressed this cycle
  assign first_now = (img_pos == '0);
  assign last_now = (ker_pos + 1'b1 == ker_end);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= EXEC_IDLE;
      d1 <= '0;
      d2 <= '0;
      img_pos <= '0;
      ker_pos <= '0;
      ker_end <= '0;
      kernel_cnt <= '0;
    end else begin
      case (state)
        EXEC_IDLE: begin
          if (start) begin
            d1 <= kcount_t'(num_in_maps);
            d2 <= num_out_maps;
            img_pos <= '0;
            ker_pos <= '0;
            ker_end <= kcount_t'(num_in_maps);
            kernel_cnt <= '0;
            state <= EXEC_RUN;
          end
        end
        EXEC_RUN: begin
          // kernel address never rewinds, only the image side does
          ker_pos <= ker_pos + 1'b1;
          if (last_now) begin
            img_pos <= '0;
            ker_end <= ker_end + d1;
            kernel_cnt <= kernel_cnt + 1'b1;
            if (kernel_cnt == d2 - 1'b1) begin
              state <= EXEC_FLUSH;
            end
          end else begin
            img_pos <= img_pos + 1'b1;
          end
        end
        EXEC_FLUSH: begin
          state <= EXEC_IDLE;
        end
        default: begin
          state <= EXEC_IDLE;
        end
      endcase
    end
  end

  // flags trail the addresses by the buffer read latency
  always_ff @(posedge clk) begin
    if (reset) begin
      ops.op_valid <= 1'b0;
      ops.op_first <= 1'b0;
      ops.op_last <= 1'b0;
    end else begin
      ops.op_valid <= (state == EXEC_RUN);
      ops.op_first <= (state == EXEC_RUN) && first_now;
      ops.op_last <= (state == EXEC_RUN) && last_now;
    end
  end

  assign image_addr = img_pos;
  assign kernel_addr = ker_pos[KER_DEPTH_BITS-1:0];
  assign ops.image_op = image_line;
  assign ops.kernel_op = kernel_line;

  // both load pointers rewind once the last pair has been read
  assign job_clear = (state == EXEC_FLUSH);

endmodule

`default_nettype wire

// ==== design/result_collector.sv ====
// result collector
// gathers the lane sums into one result line, counts them and raises done
`timescale 1ns/1ps
`default_nettype none

module result_collector import conv_freq_pkg::*; #(
  parameter int KER_DEPTH_BITS = 6
) (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire logic                    start,
  input  wire logic [KER_DEPTH_BITS:0] num_out_maps,
  input  wire logic [LANES-1:0]        lane_valid,
  input  wire result_t                 lane_acc,
  output logic                         result_valid,
  output result_t                      result_line,
  output logic                         done
);

  logic [KER_DEPTH_BITS:0] d2;
  logic [KER_DEPTH_BITS:0] count;
  logic take;

  // lanes run in lockstep, so lane 0 is valid together with the others
  assign take = &lane_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      d2 <= '0;
      count <= '0;
      result_valid <= 1'b0;
      done <= 1'b0;
    end else begin
      result_valid <= take;
      if (start) begin
        d2 <= num_out_maps;
        count <= '0;
        done <= 1'b0;
      end else if (take) begin
        count <= count + 1'b1;
      end
      // count already includes the result on the output
      if (!start && result_valid && count == d2) begin
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      result_line <= lane_acc;
    end
  end

endmodule

`default_nettype wire

// ==== design/tile_buffer.sv ====
// tile buffer
// one line written per strobe at an auto-incrementing pointer, registered read port
`timescale 1ns/1ps
`default_nettype none

module tile_buffer import conv_freq_pkg::*; #(
  parameter int DEPTH_BITS = 4
) (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  clear,
  input  wire logic                  we,
  input  wire tile_t                 wr_line,
  input  wire logic [DEPTH_BITS-1:0] rd_addr,
  output tile_t                      rd_line
);

  tile_t mem [2**DEPTH_BITS];
  logic [DEPTH_BITS-1:0] wr_ptr;

  // write pointer rewinds for the next load
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      wr_ptr <= '0;
    end else if (we) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_ptr] <= wr_line;
    end
  end

  // one cycle read latency
  always_ff @(posedge clk) begin
    rd_line <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== tb.f ====
design/conv_freq_pkg.sv
design/lane_if.sv
design/tile_buffer.sv
design/mac_sequencer.sv
design/complex_mac_lane.sv
design/result_collector.sv
design/conv_freq_top.sv
tests/tb_clock.sv
tests/conv_freq_assertions.sv
tests/tb_top.sv

// ==== tests/conv_freq_assertions.sv ====
// conv_freq protocol assertions
// bound into conv_freq_top, watches result_valid and done
`timescale 1ns/1ps
`default_nettype none

module conv_freq_assertions (
  input wire logic clk,
  input wire logic reset,
  input wire logic start,
  input wire logic result_valid,
  input wire logic done
);

  // outputs leave reset low
  reset_clears: assert property (@(posedge clk) reset |=> (!done && !result_valid))
    else $error("done or result_valid high after a reset cycle");

  no_result_while_done: assert property (@(posedge clk) disable iff (reset)
    done |-> !result_valid)
    else $error("result_valid pulsed while done was high");

  done_after_result: assert property (@(posedge clk) disable iff (reset)
    $rose(done) |-> $past(result_valid))
    else $error("done rose without a result one cycle before");

  // only a new start lets done fall
  done_holds: assert property (@(posedge clk) disable iff (reset)
    (done && !start) |=> done)
    else $error("done fell without a start");

endmodule

bind conv_freq_top conv_freq_assertions i_conv_freq_assertions (
  .clk          (clk),
  .reset        (reset),
  .start        (start),
  .result_valid (result_valid),
  .done         (done)
);

`default_nettype wire

// ==== tests/tb_clock.sv ====
// testbench clock and reset
// free-running clock, reset held high for a fixed number of cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int HALF_PERIOD_NS = 10,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // released on a rising edge like any other input
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== tests/tb_top.sv ====
// conv_freq testbench
// loads random tiles, runs jobs and checks every result line against a model
`timescale 1ns/1ps
`default_nettype none

module tb_top import conv_freq_pkg::*; ();

  localparam int IMG_DEPTH_BITS = 4;
  localparam int KER_DEPTH_BITS = 6;
  localparam int RESET_CYCLES = 8;
  localparam int IDLE_CYCLES = 10;

  // run length plus loads plus some slack for one job
  function automatic int job_cycles(int d1, int d2);
    return d1 * d2 + (d1 + d1 * d2) + 20;
  endfunction

  localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES + job_cycles(1, 1)
    + job_cycles(4, 3) + job_cycles(16, 4) + job_cycles(2, 5);

  logic clk;
  logic reset;
  logic image_we;
  tile_t image_line;
  logic kernel_we;
  tile_t kernel_line;
  logic start;
  logic [IMG_DEPTH_BITS:0] num_in_maps;
  logic [KER_DEPTH_BITS:0] num_out_maps;
  logic result_valid;
  result_t result_line;
  logic done;

  tile_t img_lines [2**IMG_DEPTH_BITS];
  tile_t ker_lines [2**KER_DEPTH_BITS];
  int cycles = 0;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  tb_clock #(.RESET_CYCLES(RESET_CYCLES)) i_tb_clock (
    .clk   (clk),
    .reset (reset)
  );

  conv_freq_top #(
    .IMG_DEPTH_BITS (IMG_DEPTH_BITS),
    .KER_DEPTH_BITS (KER_DEPTH_BITS)
  ) i_conv_freq_top (
    .clk          (clk),
    .reset        (reset),
    .image_we     (image_we),
    .image_line   (image_line),
    .kernel_we    (kernel_we),
    .kernel_line  (kernel_line),
    .start        (start),
    .num_in_maps  (num_in_maps),
    .num_out_maps (num_out_maps),
    .result_valid (result_valid),
    .result_line  (result_line),
    .done         (done)
  );

  function automatic tile_t random_line();
    tile_t line;
    for (int l = 0; l < LANES; l++) begin
      line[l].re = DATA_W'($urandom);
      line[l].im = DATA_W'($urandom);
    end
    return line;
  endfunction

  // sum over d of image line d times kernel line k*D1+d, one part of one lane
  function automatic longint expected_part(int d1, int k, int lane, bit imag);
    longint sum;
    complex_t a;
    complex_t b;
    sum = 0;
    for (int d = 0; d < d1; d++) begin
      a = img_lines[d][lane];
      b = ker_lines[k * d1 + d][lane];
      if (imag) begin
        sum += longint'(a.re) * longint'(b.im) + longint'(a.im) * longint'(b.re);
      end else begin
        sum += longint'(a.re) * longint'(b.re) - longint'(a.im) * longint'(b.im);
      end
    end
    return sum;
  endfunction

  task automatic check_value(string test_name, string what, longint expected,
                             longint actual);
    assert (actual == expected) else begin
      $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic finish_test(string test_name, int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", test_name, errors - errors_before);
    end
  endtask

  task automatic check_idle(string test_name);
    int errors_before;
    errors_before = errors;
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      @(posedge clk);
      check_value(test_name, "done", 0, longint'(done));
      check_value(test_name, "result_valid", 0, longint'(result_valid));
    end
    finish_test(test_name, errors_before);
  endtask

  // image and kernel lines go in side by side, image_we drops after D1 lines
  task automatic load_job(int d1, int d2);
    int n;
    n = d1 * d2;
    for (int i = 0; i < d1; i++) begin
      img_lines[i] = random_line();
    end
    for (int i = 0; i < n; i++) begin
      ker_lines[i] = random_line();
    end
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      image_we <= (i < d1);
      image_line <= img_lines[i % d1];
      kernel_we <= 1'b1;
      kernel_line <= ker_lines[i];
    end
    @(posedge clk);
    image_we <= 1'b0;
    kernel_we <= 1'b0;
  endtask

  // done stays up while idle and while the next job loads
  task automatic check_done_hold(string test_name, int d1, int d2);
    int errors_before;
    errors_before = errors;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      check_value(test_name, "done while idle", 1, longint'(done));
    end
    load_job(d1, d2);
    check_value(test_name, "done after load", 1, longint'(done));
    finish_test(test_name, errors_before);
  endtask

  task automatic run_job(string test_name, int d1, int d2);
    int errors_before;
    int waited;
    errors_before = errors;
    @(posedge clk);
    start <= 1'b1;
    num_in_maps <= (IMG_DEPTH_BITS + 1)'(d1);
    num_out_maps <= (KER_DEPTH_BITS + 1)'(d2);
    // the DUT samples start on this edge
    @(posedge clk);
    start <= 1'b0;
    waited = 0;
    for (int k = 0; k < d2; k++) begin
      @(posedge clk);
      waited++;
      if (k == 0) begin
        check_value(test_name, "done after start", 0, longint'(done));
      end
      while (!result_valid) begin
        @(posedge clk);
        waited++;
      end
      // a pulse set on edge n is seen here one edge later
      check_value(test_name, $sformatf("kernel %0d latency", k),
                  longint'(d1 * (k + 1) + 3), longint'(waited - 1));
      for (int l = 0; l < LANES; l++) begin
        check_value(test_name, $sformatf("kernel %0d lane %0d re", k, l),
                    expected_part(d1, k, l, 1'b0), longint'(result_line[l].re));
        check_value(test_name, $sformatf("kernel %0d lane %0d im", k, l),
                    expected_part(d1, k, l, 1'b1), longint'(result_line[l].im));
      end
    end
    @(posedge clk);
    check_value(test_name, "done after last result", 1, longint'(done));
    finish_test(test_name, errors_before);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h7219));
    image_we = 1'b0;
    image_line = '0;
    kernel_we = 1'b0;
    kernel_line = '0;
    start = 1'b0;
    num_in_maps = '0;
    num_out_maps = '0;
    @(posedge clk);
    while (reset) begin
      @(posedge clk);
    end

    check_idle("reset_idle");
    load_job(1, 1);
    run_job("single_product", 1, 1);
    load_job(16, 4);
    run_job("full_range", 16, 4);
    // leaves both load pointers away from 0 unless the job end rewinds them
    load_job(4, 3);
    run_job("four_by_three", 4, 3);

    check_done_hold("done_hold", 2, 5);
    run_job("reload_after_done", 2, 5);

    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
